// File: hdl/avr_pkg.sv
`default_nettype none

package avr_pkg;

	localparam int INSTR_W = 16;
	localparam int REG_W = 8;

	// status register as seen on the port bus
	localparam logic [5:0] IO_ADDR_SREG = 6'h3f;

	// register-register layout
	// single-register, port and branch words share it
	typedef struct packed {
		logic [5:0] op;
		logic rr_hi;
		logic [4:0] rd;
		logic [3:0] rr_lo;
	} rr_view_t;

	typedef struct packed {
		logic [3:0] op;
		logic [3:0] k_hi;
		logic [3:0] rd; // r16 to r31
		logic [3:0] k_lo;
	} imm_view_t;

	typedef union packed {
		rr_view_t rr;
		imm_view_t imm;
	} instr_t;

	typedef struct packed {
		logic i;
		logic t;
		logic h;
		logic s;
		logic v;
		logic n;
		logic z;
		logic c;
	} sreg_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_MOV, // also ldi, operand b is then K
		ALU_COM,
		ALU_NEG,
		ALU_INC,
		ALU_DEC,
		ALU_SHR, // lsr or ror by word bit 0
		ALU_ASR,
		ALU_SWAP,
		ALU_FLAG // bset and bclr
	} alu_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic use_imm; // K replaces Rr
		logic writeback;
		logic keep_z; // chained Z of cpc, sbc, sbci
		logic flags_en;
		logic in_load; // Rd takes the port read data
	} exec_ctrl_t;

	typedef struct packed {
		logic re;
		logic we;
		logic [5:0] a;
		logic [REG_W-1:0] wdata;
	} io_req_t;

endpackage

`default_nettype wire

// File: hdl/avr_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module avr_regfile (
	input logic clk,
	input logic [4:0] rd_idx,
	input logic [4:0] rr_idx,
	input logic we,
	input logic [avr_pkg::REG_W-1:0] wdata,
	output logic [avr_pkg::REG_W-1:0] rd_data,
	output logic [avr_pkg::REG_W-1:0] rr_data
);
	import avr_pkg::*;

	// r0 to r31
	logic [REG_W-1:0] regs [32];

	// single write port, always on Rd
	always_ff @(posedge clk) begin
		if (we) begin
			regs[rd_idx] <= wdata;
		end
	end

	assign rd_data = regs[rd_idx]; // also the out data
	assign rr_data = regs[rr_idx];

endmodule

`default_nettype wire

// File: hdl/avr_alu.sv
`timescale 1ns/1ps
`default_nettype none

module avr_alu (
	input avr_pkg::exec_ctrl_t ctrl,
	input avr_pkg::instr_t instr,
	input logic [avr_pkg::REG_W-1:0] a,
	input logic [avr_pkg::REG_W-1:0] b,
	input avr_pkg::sreg_t flags,
	output logic [avr_pkg::REG_W-1:0] result,
	output avr_pkg::sreg_t next_flags
);
	import avr_pkg::*;

	logic [REG_W-1:0] k;
	logic [REG_W-1:0] op_b; // register or immediate
	logic [REG_W:0] wide; // carry or borrow on top
	logic cin;
	logic upd_nsz;
	logic [REG_W-1:0] fv;

	assign k = {instr.imm.k_hi, instr.imm.k_lo};
	assign op_b = ctrl.use_imm ? k : b;
	assign cin = flags.c & (ctrl.alu_op == ALU_ADC || ctrl.alu_op == ALU_SBC);

	always_comb begin
		result = a;
		next_flags = flags;
		upd_nsz = 1'b1;
		wide = '0;
		fv = flags;
		case (ctrl.alu_op)
			ALU_ADD, ALU_ADC: begin
				wide = {1'b0, a} + {1'b0, op_b} + {{REG_W{1'b0}}, cin};
				result = wide[REG_W-1:0];
				next_flags.c = wide[REG_W];
				next_flags.h = a[3] & op_b[3] | op_b[3] & ~result[3] | ~result[3] & a[3];
				next_flags.v = a[7] & op_b[7] & ~result[7] | ~a[7] & ~op_b[7] & result[7];
			end
			ALU_SUB, ALU_SBC: begin
				wide = {1'b0, a} - {1'b0, op_b} - {{REG_W{1'b0}}, cin};
				result = wide[REG_W-1:0];
				next_flags.c = wide[REG_W]; // borrow
				next_flags.h = ~a[3] & op_b[3] | op_b[3] & result[3] | result[3] & ~a[3];
				next_flags.v = a[7] & ~op_b[7] & ~result[7] | ~a[7] & op_b[7] & result[7];
			end
			ALU_AND: begin
				result = a & op_b;
				next_flags.v = 1'b0;
			end
			ALU_OR: begin
				result = a | op_b;
				next_flags.v = 1'b0;
			end
			ALU_EOR: begin
				result = a ^ op_b;
				next_flags.v = 1'b0;
			end
			ALU_MOV: begin
				result = op_b;
				upd_nsz = 1'b0;
			end
			ALU_COM: begin
				result = ~a;
				next_flags.v = 1'b0;
				next_flags.c = 1'b1;
			end
			ALU_NEG: begin
				wide = '0 - {1'b0, a};
				result = wide[REG_W-1:0];
				next_flags.c = wide[REG_W]; // set unless a is zero
				next_flags.h = result[3] | a[3];
				next_flags.v = result == 8'h80;
			end
			ALU_INC: begin
				result = a + 8'd1;
				next_flags.v = result == 8'h80;
			end
			ALU_DEC: begin
				result = a - 8'd1;
				next_flags.v = result == 8'h7f;
			end
			ALU_SHR: begin
				// ror pulls the old carry into bit 7
				result = {instr.rr.rr_lo[0] & flags.c, a[REG_W-1:1]};
				next_flags.c = a[0];
				next_flags.v = result[REG_W-1] ^ a[0];
			end
			ALU_ASR: begin
				result = {a[REG_W-1], a[REG_W-1:1]};
				next_flags.c = a[0];
				next_flags.v = result[REG_W-1] ^ a[0];
			end
			ALU_SWAP: begin
				result = {a[3:0], a[7:4]};
				upd_nsz = 1'b0;
			end
			ALU_FLAG: begin
				// word bits 6:4 pick the flag, bit 7 set means clear
				fv[instr.rr.rd[2:0]] = ~instr.rr.rd[3];
				next_flags = sreg_t'(fv);
				upd_nsz = 1'b0;
			end
		endcase
		if (upd_nsz) begin
			next_flags.n = result[REG_W-1];
			next_flags.s = next_flags.n ^ next_flags.v;
			next_flags.z = (result == '0) && (!ctrl.keep_z || flags.z);
		end
	end

endmodule

`default_nettype wire

// File: hdl/avr_port_unit.sv
`timescale 1ns/1ps
`default_nettype none

module avr_port_unit (
	input logic clk,
	input logic rst,
	input avr_pkg::io_req_t io_req,
	input logic [avr_pkg::REG_W-1:0] io_di,
	input logic flags_en,
	input avr_pkg::sreg_t next_flags,
	output avr_pkg::sreg_t sreg,
	output logic [avr_pkg::REG_W-1:0] in_data
);
	import avr_pkg::*;

	logic sreg_hit;
	logic rd_sreg; // pending read is the status register

	assign sreg_hit = io_req.a == IO_ADDR_SREG;

	always_ff @(posedge clk) begin
		if (rst) begin
			sreg <= '0;
		end else if (flags_en) begin
			sreg <= next_flags; // alu result wins
		end else if (io_req.we && sreg_hit) begin
			sreg <= sreg_t'(io_req.wdata);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_sreg <= 1'b0;
		end else begin
			rd_sreg <= io_req.re && sreg_hit;
		end
	end

	// valid one cycle after re
	assign in_data = rd_sreg ? sreg : io_di;

	// sequencer issues at most one port access per cycle
	a_one_access: assert property (@(posedge clk) disable iff (rst)
		!(io_req.re && io_req.we))
		else $error("port read and write in the same cycle");

endmodule

`default_nettype wire

// File: hdl/avr_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module avr_sequencer #(
	parameter int pmem_width = 11
) (
	input logic clk,
	input logic rst,
	input avr_pkg::instr_t instr,
	input avr_pkg::sreg_t sreg,
	input logic [avr_pkg::REG_W-1:0] rd_data,
	output logic pmem_ce,
	output logic [pmem_width-1:0] pmem_a,
	output avr_pkg::exec_ctrl_t ctrl,
	output logic [4:0] rd_idx,
	output logic [4:0] rr_idx,
	output avr_pkg::io_req_t io_req
);
	import avr_pkg::*;

	typedef enum logic [1:0] {
		ST_NORMAL = 2'd0,
		ST_STALL = 2'd1, // fetch of a branch target
		ST_INWB = 2'd2 // port data into Rd
	} state_e;

	state_e state;
	state_e next_state;
	logic [pmem_width-1:0] pc; // word now executing
	logic [pmem_width-1:0] pc_inc;
	logic [15:0] off_ext;
	logic [REG_W-1:0] sreg_bits;
	logic [5:0] io_a;
	logic branch_hit;
	logic take;

	assign pc_inc = pc + {{(pmem_width - 1){1'b0}}, 1'b1};
	// word 0 is loaded while rst is high
	assign pmem_a = rst ? '0 : pc_inc;
	assign sreg_bits = sreg;
	assign io_a = {instr.rr.op[0], instr.rr.rr_hi, instr.rr.rr_lo};
	assign branch_hit = sreg_bits[instr.rr.rr_lo[2:0]] != instr.rr.op[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			state <= ST_NORMAL;
		end else begin
			state <= next_state;
			if (take) begin
				pc <= pc + off_ext[pmem_width-1:0]; // target minus one
			end else if (pmem_ce) begin
				pc <= pc_inc;
			end
		end
	end

	always_comb begin
		next_state = state;
		pmem_ce = 1'b0;
		take = 1'b0;
		off_ext = '0;
		ctrl = '0;
		rd_idx = instr.rr.rd;
		rr_idx = {instr.rr.rr_hi, instr.rr.rr_lo};
		io_req = '0;
		if (rst) begin
			pmem_ce = 1'b1;
		end else if (state == ST_STALL) begin
			pmem_ce = 1'b1;
			next_state = ST_NORMAL;
		end else if (state == ST_INWB) begin
			// in word still held on pmem_d
			pmem_ce = 1'b1;
			ctrl = '{alu_op: ALU_MOV, writeback: 1'b1, in_load: 1'b1, default: '0};
			next_state = ST_NORMAL;
		end else begin
			pmem_ce = 1'b1;
			case (instr.imm.op)
				4'b0000, 4'b0001, 4'b0010: begin
					case (instr.rr.op)
						6'b000001: ctrl = '{alu_op: ALU_SBC, keep_z: 1'b1, flags_en: 1'b1, default: '0};
						6'b000010: ctrl = '{alu_op: ALU_SBC, keep_z: 1'b1, writeback: 1'b1,
							flags_en: 1'b1, default: '0};
						6'b000011: ctrl = '{alu_op: ALU_ADD, writeback: 1'b1, flags_en: 1'b1, default: '0};
						6'b000101: ctrl = '{alu_op: ALU_SUB, flags_en: 1'b1, default: '0}; // cp
						6'b000110: ctrl = '{alu_op: ALU_SUB, writeback: 1'b1, flags_en: 1'b1, default: '0};
						6'b000111: ctrl = '{alu_op: ALU_ADC, writeback: 1'b1, flags_en: 1'b1, default: '0};
						6'b001000: ctrl = '{alu_op: ALU_AND, writeback: 1'b1, flags_en: 1'b1, default: '0};
						6'b001001: ctrl = '{alu_op: ALU_EOR, writeback: 1'b1, flags_en: 1'b1, default: '0};
						6'b001010: ctrl = '{alu_op: ALU_OR, writeback: 1'b1, flags_en: 1'b1, default: '0};
						6'b001011: ctrl = '{alu_op: ALU_MOV, writeback: 1'b1, default: '0};
						default: ; // nop
					endcase
				end
				4'b0011, 4'b0100, 4'b0101, 4'b0110, 4'b0111, 4'b1110: begin
					rd_idx = {1'b1, instr.imm.rd};
					case (instr.imm.op)
						4'b0011: ctrl = '{alu_op: ALU_SUB, use_imm: 1'b1, flags_en: 1'b1, default: '0};
						4'b0100: ctrl = '{alu_op: ALU_SBC, use_imm: 1'b1, writeback: 1'b1, keep_z: 1'b1,
							flags_en: 1'b1, default: '0};
						4'b0101: ctrl = '{alu_op: ALU_SUB, use_imm: 1'b1, writeback: 1'b1,
							flags_en: 1'b1, default: '0};
						4'b0110: ctrl = '{alu_op: ALU_OR, use_imm: 1'b1, writeback: 1'b1,
							flags_en: 1'b1, default: '0};
						4'b0111: ctrl = '{alu_op: ALU_AND, use_imm: 1'b1, writeback: 1'b1,
							flags_en: 1'b1, default: '0};
						default: ctrl = '{alu_op: ALU_MOV, use_imm: 1'b1, writeback: 1'b1, default: '0};
					endcase
				end
				4'b1001: begin
					if (instr.rr.op == 6'b100101 && !instr.rr.rr_hi) begin
						case (instr.rr.rr_lo)
							4'b0000: ctrl = '{alu_op: ALU_COM, writeback: 1'b1, flags_en: 1'b1, default: '0};
							4'b0001: ctrl = '{alu_op: ALU_NEG, writeback: 1'b1, flags_en: 1'b1, default: '0};
							4'b0010: ctrl = '{alu_op: ALU_SWAP, writeback: 1'b1, default: '0};
							4'b0011: ctrl = '{alu_op: ALU_INC, writeback: 1'b1, flags_en: 1'b1, default: '0};
							4'b0101: ctrl = '{alu_op: ALU_ASR, writeback: 1'b1, flags_en: 1'b1, default: '0};
							4'b0110, 4'b0111: ctrl = '{alu_op: ALU_SHR, writeback: 1'b1, flags_en: 1'b1,
								default: '0};
							4'b1010: ctrl = '{alu_op: ALU_DEC, writeback: 1'b1, flags_en: 1'b1, default: '0};
							// bset and bclr only, bit 8 set is the return group
							4'b1000: ctrl = '{alu_op: ALU_FLAG, flags_en: !instr.rr.rd[4], default: '0};
							default: ;
						endcase
					end
				end
				4'b1011: begin
					io_req.a = io_a;
					if (instr.rr.op[1]) begin
						io_req.we = 1'b1; // out
						io_req.wdata = rd_data;
					end else begin
						io_req.re = 1'b1; // in, data back next cycle
						pmem_ce = 1'b0;
						next_state = ST_INWB;
					end
				end
				4'b1100: begin
					// rjmp, 12-bit offset
					off_ext = {{4{instr.rr.op[1]}}, instr.rr.op[1:0], instr.rr.rr_hi, instr.rr.rd,
						instr.rr.rr_lo};
					take = 1'b1;
					pmem_ce = 1'b0;
					next_state = ST_STALL;
				end
				4'b1111: begin
					if (!instr.rr.op[1] && branch_hit) begin
						off_ext = {{9{instr.rr.rr_hi}}, instr.rr.rr_hi, instr.rr.rd, instr.rr.rr_lo[3]};
						take = 1'b1;
						pmem_ce = 1'b0;
						next_state = ST_STALL;
					end
				end
				default: ;
			endcase
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (rst)
		state inside {ST_NORMAL, ST_STALL, ST_INWB})
		else $error("sequencer state out of range");

endmodule

`default_nettype wire

// File: hdl/avr_core.sv
`timescale 1ns/1ps
`default_nettype none

module avr_core #(
	parameter int pmem_width = 11 // program space in words
) (
	input logic clk,
	input logic rst,
	output logic pmem_ce,
	output logic [pmem_width-1:0] pmem_a,
	input logic [avr_pkg::INSTR_W-1:0] pmem_d,
	output avr_pkg::io_req_t io_req,
	input logic [avr_pkg::REG_W-1:0] io_di
);
	import avr_pkg::*;

	instr_t instr;
	sreg_t sreg;
	sreg_t next_flags;
	exec_ctrl_t ctrl;
	logic [4:0] rd_idx;
	logic [4:0] rr_idx;
	logic [REG_W-1:0] rd_data;
	logic [REG_W-1:0] rr_data;
	logic [REG_W-1:0] alu_result;
	logic [REG_W-1:0] in_data;
	logic [REG_W-1:0] reg_wdata;

	assign instr = instr_t'(pmem_d);

	// second cycle of in writes the port data
	assign reg_wdata = ctrl.in_load ? in_data : alu_result;

	avr_sequencer #(
		.pmem_width(pmem_width)
	) u_seq (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.sreg(sreg),
		.rd_data(rd_data),
		.pmem_ce(pmem_ce),
		.pmem_a(pmem_a),
		.ctrl(ctrl),
		.rd_idx(rd_idx),
		.rr_idx(rr_idx),
		.io_req(io_req)
	);

	avr_regfile u_regs (
		.clk(clk),
		.rd_idx(rd_idx),
		.rr_idx(rr_idx),
		.we(ctrl.writeback),
		.wdata(reg_wdata),
		.rd_data(rd_data),
		.rr_data(rr_data)
	);

	avr_alu u_alu (
		.ctrl(ctrl),
		.instr(instr),
		.a(rd_data),
		.b(rr_data),
		.flags(sreg),
		.result(alu_result),
		.next_flags(next_flags)
	);

	avr_port_unit u_port (
		.clk(clk),
		.rst(rst),
		.io_req(io_req),
		.io_di(io_di),
		.flags_en(ctrl.flags_en),
		.next_flags(next_flags),
		.sreg(sreg),
		.in_data(in_data)
	);

endmodule

`default_nettype wire

// File: bench/avr_tb_encode.svh
`ifndef AVR_TB_ENCODE_SVH
`define AVR_TB_ENCODE_SVH

// register-register group, full 5-bit Rd and Rr
function automatic logic [15:0] rr_op(logic [5:0] op, logic [4:0] d, logic [4:0] r);
	return {op, r[4], d, r[3:0]};
endfunction

// immediate group, only r16 to r31
function automatic logic [15:0] imm_op(logic [3:0] op, logic [4:0] d, logic [7:0] k);
	return {op, k[7:4], d[3:0], k[3:0]};
endfunction

function automatic logic [15:0] single_op(logic [4:0] d, logic [3:0] sub);
	return {7'b1001010, d, sub};
endfunction

function automatic logic [15:0] flag_op(logic clr, logic [2:0] s);
	return {8'b1001_0100, clr, s, 4'b1000}; // bset or bclr
endfunction

function automatic logic [15:0] port_op(logic out, logic [4:0] d, logic [5:0] a);
	return {4'b1011, out, a[5:4], d, a[3:0]};
endfunction

function automatic logic [15:0] rjmp_op(logic [11:0] k);
	return {4'b1100, k};
endfunction

// clr high gives brbc
function automatic logic [15:0] branch_op(logic clr, logic [2:0] s, logic [6:0] k);
	return {5'b11110, clr, k, s};
endfunction

`endif

// File: bench/avr_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module avr_core_tb;
	import avr_pkg::*;
	`include "avr_tb_encode.svh"

	typedef enum logic [4:0] {
		K_ADD, K_ADC, K_SUB, K_SBC, K_AND, K_OR, K_EOR, K_MOV, K_CP, K_CPC,
		K_SUBI, K_SBCI, K_CPI, K_ANDI, K_ORI, K_COM, K_NEG, K_INC, K_DEC, K_LSR,
		K_ROR, K_ASR, K_SWAP, K_BSET, K_BCLR, K_BRBS, K_BRBC, K_RJMP, K_INEXT
	} kind_e;

	typedef struct packed {
		kind_e kind;
		logic [7:0] a;
		logic [7:0] b;
		sreg_t flags_in;
		logic [7:0] exp_res;
		sreg_t exp_sreg;
		logic exp_marker; // untaken branch lets the marker out
	} case_t;

	localparam logic [4:0] R16 = 5'd16;
	localparam logic [4:0] R17 = 5'd17;
	localparam logic [4:0] R18 = 5'd18;
	localparam logic [4:0] R19 = 5'd19;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic pmem_ce;
	logic [10:0] pmem_a;
	logic [15:0] pmem_d = '0;
	io_req_t io_req;
	logic [7:0] io_di = '0;
	logic [15:0] pmem [2048];
	logic [7:0] ports [64];
	logic fetch;
	logic [10:0] fetch_a;
	logic rd_pend;
	logic [5:0] rd_a;
	logic [13:0] wr_q [$]; // {addr, data}
	case_t table_q [$];
	int errors = 0;
	int checks = 0;
	int timeouts = 0;
	int seed = 32'h0fea_5bba;
	bit timed_out = 1'b0;

	avr_core #(.pmem_width(11)) dut (
		.clk(clk), .rst(rst), .pmem_ce(pmem_ce), .pmem_a(pmem_a),
		.pmem_d(pmem_d), .io_req(io_req), .io_di(io_di)
	);

	always #4 clk = ~clk;

	// outputs are settled by the falling edge
	always @(negedge clk) begin
		fetch = pmem_ce;
		fetch_a = pmem_a;
		rd_pend = io_req.re;
		rd_a = io_req.a;
		if (!rst && io_req.we && io_req.a != IO_ADDR_SREG)
			wr_q.push_back({io_req.a, io_req.wdata});
	end

	always @(posedge clk) begin
		#1;
		if (fetch) pmem_d = pmem[fetch_a];
		if (rd_pend) io_di = ports[rd_a];
	end

	function automatic case_t fill_expect(case_t c);
		logic [7:0] r;
		logic [7:0] fr;
		logic [7:0] fb;
		sreg_t f;
		int s;
		int cy;
		logic nsz;
		logic chain;
		r = c.a;
		f = c.flags_in;
		fb = c.flags_in;
		nsz = 1'b1;
		cy = 0;
		chain = c.kind inside {K_SBC, K_CPC, K_SBCI};
		if (chain || c.kind == K_ADC) cy = int'(c.flags_in.c);
		c.exp_marker = 1'b0;
		case (c.kind)
			K_ADD, K_ADC: begin
				s = int'(c.a) + int'(c.b) + cy;
				r = s[7:0];
				f.c = s > 255;
				f.h = int'(c.a[3:0]) + int'(c.b[3:0]) + cy > 15;
				f.v = c.a[7] == c.b[7] && r[7] != c.a[7];
			end
			K_SUB, K_SBC, K_CP, K_CPC, K_SUBI, K_SBCI, K_CPI: begin
				s = int'(c.a) - int'(c.b) - cy;
				r = s[7:0];
				f.c = s < 0; // borrow
				f.h = int'(c.a[3:0]) < int'(c.b[3:0]) + cy;
				f.v = c.a[7] != c.b[7] && r[7] != c.a[7];
			end
			K_AND, K_ANDI: begin
				r = c.a & c.b;
				f.v = 1'b0;
			end
			K_OR, K_ORI: begin
				r = c.a | c.b;
				f.v = 1'b0;
			end
			K_EOR: begin
				r = c.a ^ c.b;
				f.v = 1'b0;
			end
			K_COM: begin
				r = ~c.a;
				f.v = 1'b0;
				f.c = 1'b1;
			end
			K_NEG: begin
				r = 8'd0 - c.a;
				f.c = c.a != 8'd0;
				f.h = c.a[3:0] != 4'd0;
				f.v = c.a == 8'h80;
			end
			K_INC: begin
				r = c.a + 8'd1;
				f.v = c.a == 8'h7f;
			end
			K_DEC: begin
				r = c.a - 8'd1;
				f.v = c.a == 8'h80;
			end
			K_LSR: begin
				r = {1'b0, c.a[7:1]};
				f.c = c.a[0];
				f.v = c.a[0]; // n is always clear
			end
			K_ROR: begin
				r = {c.flags_in.c, c.a[7:1]};
				f.c = c.a[0];
				f.v = c.flags_in.c ^ c.a[0];
			end
			K_ASR: begin
				r = {c.a[7], c.a[7:1]};
				f.c = c.a[0];
				f.v = c.a[7] ^ c.a[0];
			end
			K_SWAP: begin
				r = {c.a[3:0], c.a[7:4]};
				nsz = 1'b0;
			end
			K_MOV, K_INEXT: begin
				r = c.b;
				nsz = 1'b0;
			end
			K_BSET, K_BCLR: begin
				fb[c.b[2:0]] = c.kind == K_BSET;
				f = sreg_t'(fb);
				nsz = 1'b0;
			end
			K_BRBS: begin
				c.exp_marker = !fb[c.b[2:0]];
				nsz = 1'b0;
			end
			K_BRBC: begin
				c.exp_marker = fb[c.b[2:0]];
				nsz = 1'b0;
			end
			default: nsz = 1'b0; // rjmp
		endcase
		fr = r;
		if (c.kind inside {K_CP, K_CPC, K_CPI}) r = c.a; // compare keeps Rd
		if (nsz) begin
			f.n = fr[7];
			f.s = f.n ^ f.v;
			f.z = fr == 8'd0 && (!chain || c.flags_in.z);
		end
		c.exp_res = r;
		c.exp_sreg = f;
		return c;
	endfunction

	function automatic logic [15:0] op_word(case_t c);
		case (c.kind)
			K_ADD: return rr_op(6'b000011, R16, R17);
			K_ADC: return rr_op(6'b000111, R16, R17);
			K_SUB: return rr_op(6'b000110, R16, R17);
			K_SBC: return rr_op(6'b000010, R16, R17);
			K_AND: return rr_op(6'b001000, R16, R17);
			K_OR: return rr_op(6'b001010, R16, R17);
			K_EOR: return rr_op(6'b001001, R16, R17);
			K_MOV: return rr_op(6'b001011, R16, R17);
			K_CP: return rr_op(6'b000101, R16, R17);
			K_CPC: return rr_op(6'b000001, R16, R17);
			K_SUBI: return imm_op(4'b0101, R16, c.b);
			K_SBCI: return imm_op(4'b0100, R16, c.b);
			K_CPI: return imm_op(4'b0011, R16, c.b);
			K_ANDI: return imm_op(4'b0111, R16, c.b);
			K_ORI: return imm_op(4'b0110, R16, c.b);
			K_COM: return single_op(R16, 4'b0000);
			K_NEG: return single_op(R16, 4'b0001);
			K_INC: return single_op(R16, 4'b0011);
			K_DEC: return single_op(R16, 4'b1010);
			K_LSR: return single_op(R16, 4'b0110);
			K_ROR: return single_op(R16, 4'b0111);
			K_ASR: return single_op(R16, 4'b0101);
			K_SWAP: return single_op(R16, 4'b0010);
			K_BSET: return flag_op(1'b0, c.b[2:0]);
			K_BCLR: return flag_op(1'b1, c.b[2:0]);
			K_BRBS: return branch_op(1'b0, c.b[2:0], 7'd1); // over the marker
			K_BRBC: return branch_op(1'b1, c.b[2:0], 7'd1);
			K_RJMP: return rjmp_op(12'd1);
			default: return port_op(1'b0, R16, 6'h05);
		endcase
	endfunction

	task automatic add_row(kind_e k, logic [7:0] a, logic [7:0] b, sreg_t f);
		case_t c;
		c = '0;
		c.kind = k;
		c.a = a;
		c.b = b;
		c.flags_in = f;
		table_q.push_back(fill_expect(c));
	endtask

	task automatic check_byte(string what, logic [7:0] got, logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_sreg(string what, sreg_t got, sreg_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s got %08b expected %08b (ithsvnzc)", $time, what, got, exp);
		end
	endtask

	// next external port write, its address checked
	task automatic expect_write(logic [5:0] ea, output logic [7:0] d);
		int n;
		n = 0;
		d = '0;
		while (wr_q.size() == 0 && n < 200) begin
			@(posedge clk);
			n++;
		end
		if (wr_q.size() == 0) begin
			$display("no port write seen before timeout");
			timeouts++;
			timed_out = 1'b1;
		end else begin
			d = wr_q[0][7:0];
			check_byte("port address", {2'b00, wr_q[0][13:8]}, {2'b00, ea});
			void'(wr_q.pop_front());
		end
	endtask

	task automatic run_case(case_t c);
		logic [7:0] d;
		int n;
		n = (c.kind inside {K_BRBS, K_BRBC, K_RJMP}) ? 6 : 5;
		@(posedge clk);
		#1;
		rst = 1'b1;
		for (int i = 0; i < 2048; i++) pmem[i] = {5'd0, 11'(i)}; // unreachable filler
		pmem[0] = imm_op(4'b1110, R16, c.a); // ldi
		pmem[1] = imm_op(4'b1110, R17, c.b);
		pmem[2] = imm_op(4'b1110, R19, c.flags_in);
		pmem[3] = port_op(1'b1, R19, IO_ADDR_SREG);
		pmem[4] = op_word(c);
		pmem[5] = port_op(1'b1, R17, 6'h12); // marker
		pmem[n] = port_op(1'b1, R16, 6'h10);
		pmem[n + 1] = port_op(1'b0, R18, IO_ADDR_SREG);
		pmem[n + 2] = port_op(1'b1, R18, 6'h11);
		pmem[n + 3] = rjmp_op(12'hfff); // park
		ports[5] = c.b;
		repeat (10) @(posedge clk);
		#1;
		wr_q.delete();
		rst = 1'b0;
		if (c.exp_marker) begin
			expect_write(6'h12, d);
			if (!timed_out) check_byte("marker", d, c.b);
		end
		if (!timed_out) expect_write(6'h10, d);
		if (!timed_out) check_byte($sformatf("%s result", c.kind.name()), d, c.exp_res);
		if (!timed_out) expect_write(6'h11, d);
		if (!timed_out) check_sreg($sformatf("%s status", c.kind.name()), sreg_t'(d), c.exp_sreg);
	endtask

	initial begin
		logic [31:0] rnd;
		for (int i = 0; i < 64; i++) ports[i] = 8'(i * 7 + 3);
		add_row(K_ADD, 8'h7f, 8'h01, '0);
		add_row(K_SUB, 8'h00, 8'h01, '0);
		add_row(K_SBCI, 8'h05, 8'h04, sreg_t'(8'h01)); // zero result, Z stays clear
		add_row(K_CPC, 8'h05, 8'h05, sreg_t'(8'h02));
		add_row(K_NEG, 8'h80, 8'h00, '0);
		add_row(K_NEG, 8'h00, 8'h00, '0);
		add_row(K_DEC, 8'h80, 8'h00, '0);
		add_row(K_INC, 8'h7f, 8'h00, '0);
		add_row(K_BRBS, 8'h3c, 8'h00, sreg_t'(8'h01));
		add_row(K_BRBS, 8'h5a, 8'h01, '0); // z clear, falls through
		add_row(K_BRBC, 8'h5a, 8'h01, sreg_t'(8'h02)); // z set, falls through
		add_row(K_BRBC, 8'h66, 8'h01, '0);
		// every flag set from all clear and cleared from all set
		for (int i = 0; i < 8; i++) begin
			add_row(K_BSET, 8'h11, 8'(i), '0);
			add_row(K_BCLR, 8'h22, 8'(i), sreg_t'(8'hff));
		end
		for (int k = 0; k <= int'(K_INEXT); k++) begin
			repeat (2) begin
				rnd = $random(seed);
				add_row(kind_e'(k), rnd[7:0], rnd[15:8], sreg_t'(rnd[23:16]));
			end
		end
		foreach (table_q[i]) begin
			if (!timed_out) run_case(table_q[i]);
		end
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+bench
hdl/avr_pkg.sv
hdl/avr_regfile.sv
hdl/avr_alu.sv
hdl/avr_port_unit.sv
hdl/avr_sequencer.sv
hdl/avr_core.sv
bench/avr_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module avr_core_tb -Mdir obj_dir
./obj_dir/Vavr_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
